// ==== hdl/decodePkg.sv ====
package decodePkg;

	//////////////////////////////////////////////////
	// field widths
	//////////////////////////////////////////////////
	localparam int instrWidth    = 32;
	localparam int opcodeWidth   = 6;  // primary opcode, bits 0-5
	localparam int regWidth      = 5;
	localparam int immWidth      = 24; // widest immediate, I-form LI
	localparam int mdImmWidth    = 6;  // MD mb/me
	localparam int dImmWidth     = 16;
	localparam int unitCodeWidth = 3;

	//////////////////////////////////////////////////
	// primary opcodes
	//////////////////////////////////////////////////
	localparam logic [0:opcodeWidth-1] opcodeMd    = 6'd30;
	localparam logic [0:opcodeWidth-1] opcodeAddi  = 6'd14;
	localparam logic [0:opcodeWidth-1] opcodeAddis = 6'd15;
	localparam logic [0:opcodeWidth-1] opcodeLwz   = 6'd32;
	localparam logic [0:opcodeWidth-1] opcodeStw   = 6'd36;
	localparam logic [0:opcodeWidth-1] opcodeB     = 6'd18;

	// MD rotates keep their extended opcode as the code,
	// MDS rotates likewise (8 and 9)
	typedef enum logic [0:3] {
		opRldicl = 4'd0,
		opRldicr = 4'd1,
		opRldic  = 4'd2,
		opRldimi = 4'd3,
		opAddi   = 4'd4,
		opAddis  = 4'd5,
		opLwz    = 4'd6,
		opStw    = 4'd7,
		opRldcl  = 4'd8,
		opRldcr  = 4'd9,
		opB      = 4'd10,
		opNone   = 4'd15
	} decodedOp_t;

endpackage

// ==== hdl/mdFormatDecoder.sv ====
module mdFormatDecoder #(
	parameter logic [0:decodePkg::unitCodeWidth-1] fxUnitCode = 3'd0
) (
	input  logic                                    clock_i,
	input  logic                                    rstN_i,
	input  logic                                    enable_i,
	input  logic [0:decodePkg::instrWidth-1]        instruction_i,
	output logic                                    hit_o,
	output decodePkg::decodedOp_t                   op_o,
	output logic [0:decodePkg::regWidth-1]          reg1_o,
	output logic [0:decodePkg::regWidth-1]          reg2_o,
	output logic [0:decodePkg::regWidth-1]          reg3_o,
	output logic [0:decodePkg::mdImmWidth-1]        imm_o,
	output logic                                    bit1_o,
	output logic                                    bit2_o,
	output logic [0:decodePkg::unitCodeWidth-1]     unitCode_o
);
	import decodePkg::*;

	logic       isMd;   // primary opcode 30
	logic [0:2] mdXo;   // MD extended opcode
	logic [0:3] mdsXo;  // MDS extended opcode, one bit longer
	decodedOp_t decOp;
	logic       decHit;

	assign isMd  = (instruction_i[0:opcodeWidth-1] == opcodeMd);
	assign mdXo  = instruction_i[27:29];
	assign mdsXo = instruction_i[27:30];

	//////////////////////////////////////////////////
	// extended opcode decode
	//////////////////////////////////////////////////
	always_comb begin
		decOp = opNone;
		if (isMd) begin
			case (mdXo)
				3'd0: decOp = opRldicl;
				3'd1: decOp = opRldicr;
				3'd2: decOp = opRldic;
				3'd3: decOp = opRldimi;
				default: begin
					// MDS codes 8/9 sit under MD code 4
					case (mdsXo)
						4'd8:    decOp = opRldcl;
						4'd9:    decOp = opRldcr;
						default: decOp = opNone;
					endcase
				end
			endcase
		end
	end

	assign decHit = (decOp != opNone);

	//////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////
	always_ff @(posedge clock_i or negedge rstN_i) begin
		if (!rstN_i) begin
			hit_o      <= 1'b0;
			op_o       <= opNone;
			reg1_o     <= '0;
			reg2_o     <= '0;
			reg3_o     <= '0;
			imm_o      <= '0;
			bit1_o     <= 1'b0;
			bit2_o     <= 1'b0;
			unitCode_o <= '0;
		end else begin
			hit_o <= enable_i & decHit;
			if (enable_i && isMd) begin
				op_o       <= decOp;
				reg1_o     <= instruction_i[6:10];  // RS
				reg2_o     <= instruction_i[11:15]; // RA
				reg3_o     <= instruction_i[16:20]; // sh, or RB for MDS
				imm_o      <= instruction_i[21:26]; // mb/me
				bit1_o     <= instruction_i[30];
				bit2_o     <= instruction_i[31];    // Rc
				unitCode_o <= fxUnitCode;
			end
		end
	end

endmodule

// ==== hdl/dFormatDecoder.sv ====
module dFormatDecoder #(
	parameter logic [0:decodePkg::unitCodeWidth-1] ldStUnitCode = 3'd2,
	parameter logic [0:decodePkg::unitCodeWidth-1] fxUnitCode   = 3'd0
) (
	input  logic                                    clock_i,
	input  logic                                    rstN_i,
	input  logic                                    enable_i,
	input  logic [0:decodePkg::instrWidth-1]        instruction_i,
	output logic                                    hit_o,
	output decodePkg::decodedOp_t                   op_o,
	output logic [0:decodePkg::regWidth-1]          reg1_o,
	output logic [0:decodePkg::regWidth-1]          reg2_o,
	output logic [0:decodePkg::regWidth-1]          reg3_o,
	output logic [0:decodePkg::dImmWidth-1]         imm_o,
	output logic [0:decodePkg::unitCodeWidth-1]     unitCode_o
);
	import decodePkg::*;

	logic [0:opcodeWidth-1]   primary;
	decodedOp_t               decOp;
	logic [0:unitCodeWidth-1] decUnit;
	logic                     decHit;

	assign primary = instruction_i[0:opcodeWidth-1];

	// arithmetic goes to FX, memory ops to load/store
	always_comb begin
		decOp   = opNone;
		decUnit = fxUnitCode;
		case (primary)
			opcodeAddi:  decOp = opAddi;
			opcodeAddis: decOp = opAddis;
			opcodeLwz: begin
				decOp   = opLwz;
				decUnit = ldStUnitCode;
			end
			opcodeStw: begin
				decOp   = opStw;
				decUnit = ldStUnitCode;
			end
			default: decOp = opNone;
		endcase
	end

	assign decHit = (decOp != opNone);

	//////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////
	always_ff @(posedge clock_i or negedge rstN_i) begin
		if (!rstN_i) begin
			hit_o      <= 1'b0;
			op_o       <= opNone;
			reg1_o     <= '0;
			reg2_o     <= '0;
			reg3_o     <= '0;
			imm_o      <= '0;
			unitCode_o <= '0;
		end else begin
			hit_o <= enable_i & decHit;
			if (enable_i && decHit) begin
				op_o       <= decOp;
				reg1_o     <= instruction_i[6:10];  // RT, or RS for stw
				reg2_o     <= instruction_i[11:15]; // RA
				reg3_o     <= '0;                   // no third register in D-form
				imm_o      <= instruction_i[16:31]; // raw D field
				unitCode_o <= decUnit;
			end
		end
	end

endmodule

// ==== hdl/iFormatDecoder.sv ====
module iFormatDecoder #(
	parameter logic [0:decodePkg::unitCodeWidth-1] branchUnitCode = 3'd3
) (
	input  logic                                    clock_i,
	input  logic                                    rstN_i,
	input  logic                                    enable_i,
	input  logic [0:decodePkg::instrWidth-1]        instruction_i,
	output logic                                    hit_o,
	output decodePkg::decodedOp_t                   op_o,
	output logic [0:decodePkg::immWidth-1]          imm_o,
	output logic                                    bit1_o,
	output logic                                    bit2_o,
	output logic [0:decodePkg::unitCodeWidth-1]     unitCode_o
);
	import decodePkg::*;

	logic isBranch;

	assign isBranch = (instruction_i[0:opcodeWidth-1] == opcodeB);

	//////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////
	always_ff @(posedge clock_i or negedge rstN_i) begin
		if (!rstN_i) begin
			hit_o      <= 1'b0;
			op_o       <= opNone;
			imm_o      <= '0;
			bit1_o     <= 1'b0;
			bit2_o     <= 1'b0;
			unitCode_o <= '0;
		end else begin
			hit_o <= enable_i & isBranch;
			if (enable_i && isBranch) begin
				op_o       <= opB;
				imm_o      <= instruction_i[6:29]; // LI, word offset
				bit1_o     <= instruction_i[30];   // AA
				bit2_o     <= instruction_i[31];   // LK
				unitCode_o <= branchUnitCode;
			end
		end
	end

endmodule

// ==== hdl/dispatchSelect.sv ====
module dispatchSelect (
	input  logic                                clock_i,
	input  logic                                rstN_i,
	input  logic                                enable_i,
	// MD decoder
	input  logic                                hitMd_i,
	input  decodePkg::decodedOp_t               opMd_i,
	input  logic [0:decodePkg::regWidth-1]      reg1Md_i,
	input  logic [0:decodePkg::regWidth-1]      reg2Md_i,
	input  logic [0:decodePkg::regWidth-1]      reg3Md_i,
	input  logic [0:decodePkg::mdImmWidth-1]    immMd_i,
	input  logic                                bit1Md_i,
	input  logic                                bit2Md_i,
	input  logic [0:decodePkg::unitCodeWidth-1] unitCodeMd_i,
	// D decoder
	input  logic                                hitD_i,
	input  decodePkg::decodedOp_t               opD_i,
	input  logic [0:decodePkg::regWidth-1]      reg1D_i,
	input  logic [0:decodePkg::regWidth-1]      reg2D_i,
	input  logic [0:decodePkg::regWidth-1]      reg3D_i,
	input  logic [0:decodePkg::dImmWidth-1]     immD_i,
	input  logic [0:decodePkg::unitCodeWidth-1] unitCodeD_i,
	// I decoder
	input  logic                                hitI_i,
	input  decodePkg::decodedOp_t               opI_i,
	input  logic [0:decodePkg::immWidth-1]      immI_i,
	input  logic                                bit1I_i,
	input  logic                                bit2I_i,
	input  logic [0:decodePkg::unitCodeWidth-1] unitCodeI_i,
	// dispatch record
	output logic                                valid_o,
	output logic                                illegal_o,
	output decodePkg::decodedOp_t               op_o,
	output logic [0:decodePkg::regWidth-1]      reg1_o,
	output logic [0:decodePkg::regWidth-1]      reg2_o,
	output logic [0:decodePkg::regWidth-1]      reg3_o,
	output logic [0:decodePkg::immWidth-1]      imm_o,
	output logic                                bit1_o,
	output logic                                bit2_o,
	output logic [0:decodePkg::unitCodeWidth-1] unitCode_o
);
	import decodePkg::*;

	logic                     enableDly; // lines up with the decoder outputs
	logic                     anyHit;
	decodedOp_t               selOp;
	logic [0:regWidth-1]      selReg1;
	logic [0:regWidth-1]      selReg2;
	logic [0:regWidth-1]      selReg3;
	logic [0:immWidth-1]      selImm;
	logic                     selBit1;
	logic                     selBit2;
	logic [0:unitCodeWidth-1] selUnit;

	assign anyHit = hitMd_i | hitD_i | hitI_i;

	//////////////////////////////////////////////////
	// one-hot merge, opcodes are disjoint
	//////////////////////////////////////////////////
	always_comb begin
		selOp   = opNone;
		selReg1 = '0;
		selReg2 = '0;
		selReg3 = '0;
		selImm  = '0;
		selBit1 = 1'b0;
		selBit2 = 1'b0;
		selUnit = '0;
		unique case (1'b1)
			hitMd_i: begin
				selOp   = opMd_i;
				selReg1 = reg1Md_i;
				selReg2 = reg2Md_i;
				selReg3 = reg3Md_i;
				selImm  = {{(immWidth-mdImmWidth){1'b0}}, immMd_i};
				selBit1 = bit1Md_i;
				selBit2 = bit2Md_i;
				selUnit = unitCodeMd_i;
			end
			hitD_i: begin
				selOp   = opD_i;
				selReg1 = reg1D_i;
				selReg2 = reg2D_i;
				selReg3 = reg3D_i;
				selImm  = {{(immWidth-dImmWidth){1'b0}}, immD_i};
				selUnit = unitCodeD_i;
			end
			hitI_i: begin
				selOp   = opI_i; // branch has no register fields
				selImm  = immI_i;
				selBit1 = bit1I_i;
				selBit2 = bit2I_i;
				selUnit = unitCodeI_i;
			end
			default: selOp = opNone;
		endcase
	end

	//////////////////////////////////////////////////
	// record register
	//////////////////////////////////////////////////
	always_ff @(posedge clock_i or negedge rstN_i) begin
		if (!rstN_i) begin
			enableDly  <= 1'b0;
			valid_o    <= 1'b0;
			illegal_o  <= 1'b0;
			op_o       <= opNone;
			reg1_o     <= '0;
			reg2_o     <= '0;
			reg3_o     <= '0;
			imm_o      <= '0;
			bit1_o     <= 1'b0;
			bit2_o     <= 1'b0;
			unitCode_o <= '0;
		end else begin
			enableDly <= enable_i;
			valid_o   <= anyHit;
			illegal_o <= enableDly & ~anyHit; // enabled word nobody claimed
			if (anyHit) begin
				op_o       <= selOp;
				reg1_o     <= selReg1;
				reg2_o     <= selReg2;
				reg3_o     <= selReg3;
				imm_o      <= selImm;
				bit1_o     <= selBit1;
				bit2_o     <= selBit2;
				unitCode_o <= selUnit;
			end else if (enableDly) begin
				op_o <= opNone;
			end
		end
	end

endmodule

// ==== hdl/decodeStage.sv ====
module decodeStage #(
	parameter logic [0:decodePkg::unitCodeWidth-1] fxUnitCode     = 3'd0,
	parameter logic [0:decodePkg::unitCodeWidth-1] ldStUnitCode   = 3'd2,
	parameter logic [0:decodePkg::unitCodeWidth-1] branchUnitCode = 3'd3
) (
	input  logic                                clock_i,
	input  logic                                rstN_i,
	input  logic                                enable_i,
	input  logic [0:decodePkg::instrWidth-1]    instruction_i,
	output logic                                valid_o,
	output logic                                illegal_o,
	output decodePkg::decodedOp_t               op_o,
	output logic [0:decodePkg::regWidth-1]      reg1_o,
	output logic [0:decodePkg::regWidth-1]      reg2_o,
	output logic [0:decodePkg::regWidth-1]      reg3_o,
	output logic [0:decodePkg::immWidth-1]      imm_o,
	output logic                                bit1_o,
	output logic                                bit2_o,
	output logic [0:decodePkg::unitCodeWidth-1] unitCode_o
);
	import decodePkg::*;

	//////////////////////////////////////////////////
	// decoder to selector wiring
	//////////////////////////////////////////////////
	logic                     hitMd, hitD, hitI;
	decodedOp_t               opMd, opD, opI;
	logic [0:regWidth-1]      reg1Md, reg2Md, reg3Md;
	logic [0:regWidth-1]      reg1D, reg2D, reg3D;
	logic [0:mdImmWidth-1]    immMd;
	logic [0:dImmWidth-1]     immD;
	logic [0:immWidth-1]      immI;
	logic                     bit1Md, bit2Md, bit1I, bit2I;
	logic [0:unitCodeWidth-1] unitMd, unitD, unitI;

	mdFormatDecoder #(.fxUnitCode(fxUnitCode)) mdDecoder (
		.clock_i(clock_i), .rstN_i(rstN_i), .enable_i(enable_i),
		.instruction_i(instruction_i),
		.hit_o(hitMd), .op_o(opMd),
		.reg1_o(reg1Md), .reg2_o(reg2Md), .reg3_o(reg3Md),
		.imm_o(immMd), .bit1_o(bit1Md), .bit2_o(bit2Md),
		.unitCode_o(unitMd)
	);

	dFormatDecoder #(.ldStUnitCode(ldStUnitCode), .fxUnitCode(fxUnitCode)) dDecoder (
		.clock_i(clock_i), .rstN_i(rstN_i), .enable_i(enable_i),
		.instruction_i(instruction_i),
		.hit_o(hitD), .op_o(opD),
		.reg1_o(reg1D), .reg2_o(reg2D), .reg3_o(reg3D),
		.imm_o(immD), .unitCode_o(unitD)
	);

	iFormatDecoder #(.branchUnitCode(branchUnitCode)) iDecoder (
		.clock_i(clock_i), .rstN_i(rstN_i), .enable_i(enable_i),
		.instruction_i(instruction_i),
		.hit_o(hitI), .op_o(opI), .imm_o(immI),
		.bit1_o(bit1I), .bit2_o(bit2I), .unitCode_o(unitI)
	);

	dispatchSelect selector (
		.clock_i(clock_i), .rstN_i(rstN_i), .enable_i(enable_i),
		.hitMd_i(hitMd), .opMd_i(opMd), .reg1Md_i(reg1Md), .reg2Md_i(reg2Md),
		.reg3Md_i(reg3Md), .immMd_i(immMd), .bit1Md_i(bit1Md), .bit2Md_i(bit2Md),
		.unitCodeMd_i(unitMd),
		.hitD_i(hitD), .opD_i(opD), .reg1D_i(reg1D), .reg2D_i(reg2D),
		.reg3D_i(reg3D), .immD_i(immD), .unitCodeD_i(unitD),
		.hitI_i(hitI), .opI_i(opI), .immI_i(immI), .bit1I_i(bit1I),
		.bit2I_i(bit2I), .unitCodeI_i(unitI),
		.valid_o(valid_o), .illegal_o(illegal_o), .op_o(op_o),
		.reg1_o(reg1_o), .reg2_o(reg2_o), .reg3_o(reg3_o), .imm_o(imm_o),
		.bit1_o(bit1_o), .bit2_o(bit2_o), .unitCode_o(unitCode_o)
	);

endmodule

// ==== testbench/decodeStageTb.sv ====
module decodeStageTb;
	import decodePkg::*;

	localparam int clockPeriod  = 8;
	localparam int resetCycles  = 10;
	localparam int mdWords      = 16;
	localparam int mdsWords     = 8;
	localparam int dWords       = 12;
	localparam int branchWords  = 8;
	localparam int illegalSteps = 16;
	localparam int streamWords  = 200;
	localparam int flushSteps   = 2;
	localparam int totalCycles  = resetCycles + mdWords + mdsWords + dWords + branchWords
		+ illegalSteps + streamWords + flushSteps;
	localparam int timeoutTime  = (totalCycles + 50) * clockPeriod;

	// default unit codes of the top level
	localparam logic [0:unitCodeWidth-1] fxCode     = 3'd0;
	localparam logic [0:unitCodeWidth-1] ldStCode   = 3'd2;
	localparam logic [0:unitCodeWidth-1] branchCode = 3'd3;

	typedef struct packed {
		logic                     valid;
		logic                     illegal;
		decodedOp_t               op;
		logic [0:regWidth-1]      reg1;
		logic [0:regWidth-1]      reg2;
		logic [0:regWidth-1]      reg3;
		logic [0:immWidth-1]      imm;
		logic                     bit1;
		logic                     bit2;
		logic [0:unitCodeWidth-1] unit;
	} record_t;

	logic                     clock_i = 1'b0;
	logic                     rstN_i;
	logic                     enable_i;
	logic [0:instrWidth-1]    instruction_i;
	logic                     valid_o;
	logic                     illegal_o;
	decodedOp_t               op_o;
	logic [0:regWidth-1]      reg1_o;
	logic [0:regWidth-1]      reg2_o;
	logic [0:regWidth-1]      reg3_o;
	logic [0:immWidth-1]      imm_o;
	logic                     bit1_o;
	logic                     bit2_o;
	logic [0:unitCodeWidth-1] unitCode_o;

	record_t     expQ[$];  // words in flight
	string       nameQ[$];
	logic [15:0] lfsrState;

	decodeStage UUT (
		.clock_i(clock_i), .rstN_i(rstN_i), .enable_i(enable_i),
		.instruction_i(instruction_i),
		.valid_o(valid_o), .illegal_o(illegal_o), .op_o(op_o),
		.reg1_o(reg1_o), .reg2_o(reg2_o), .reg3_o(reg3_o), .imm_o(imm_o),
		.bit1_o(bit1_o), .bit2_o(bit2_o), .unitCode_o(unitCode_o)
	);

	always #(clockPeriod / 2) clock_i = ~clock_i;

	initial begin
		#(timeoutTime);
		stopOnError("timeout, the tests did not finish in time");
	end

	//////////////////////////////////////////////////
	// reporting and compare tasks
	//////////////////////////////////////////////////
	task automatic stopOnError(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkFlag(input string testName, input string what, input logic expected,
		input logic actual);
		if (actual !== expected)
			stopOnError($sformatf("Fail %s %s expected %0b actual %0b", testName, what,
				expected, actual));
	endtask

	task automatic checkOp(input string testName, input decodedOp_t expected,
		input decodedOp_t actual);
		if (actual !== expected)
			stopOnError($sformatf("Fail %s op expected %s actual %s", testName,
				expected.name(), actual.name()));
	endtask

	task automatic checkReg(input string testName, input string what,
		input logic [0:regWidth-1] expected, input logic [0:regWidth-1] actual);
		if (actual !== expected)
			stopOnError($sformatf("Fail %s %s expected %0d actual %0d", testName, what,
				expected, actual));
	endtask

	task automatic checkImm(input string testName, input logic [0:immWidth-1] expected,
		input logic [0:immWidth-1] actual);
		if (actual !== expected)
			stopOnError($sformatf("Fail %s imm expected %06h actual %06h", testName,
				expected, actual));
	endtask

	task automatic checkUnit(input string testName, input logic [0:unitCodeWidth-1] expected,
		input logic [0:unitCodeWidth-1] actual);
		if (actual !== expected)
			stopOnError($sformatf("Fail %s unit expected %0d actual %0d", testName,
				expected, actual));
	endtask

	// data fields only matter on a valid record
	task automatic compareRecord(input string testName, input record_t exp);
		checkFlag(testName, "valid", exp.valid, valid_o);
		checkFlag(testName, "illegal", exp.illegal, illegal_o);
		if (exp.illegal)
			checkOp(testName, opNone, op_o);
		if (exp.valid) begin
			checkOp(testName, exp.op, op_o);
			checkReg(testName, "reg1", exp.reg1, reg1_o);
			checkReg(testName, "reg2", exp.reg2, reg2_o);
			checkReg(testName, "reg3", exp.reg3, reg3_o);
			checkImm(testName, exp.imm, imm_o);
			checkFlag(testName, "bit1", exp.bit1, bit1_o);
			checkFlag(testName, "bit2", exp.bit2, bit2_o);
			checkUnit(testName, exp.unit, unitCode_o);
		end
	endtask

	//////////////////////////////////////////////////
	// reference decode and random source
	//////////////////////////////////////////////////
	function automatic record_t expectedRecord(input logic en, input logic [0:instrWidth-1] w);
		record_t r;
		r = '0;
		r.op = opNone;
		if (!en)
			return r;  // idle word leaves both flags low
		case (w[0:5])
			opcodeMd: begin
				case (w[27:29])
					3'd0: r.op = opRldicl;
					3'd1: r.op = opRldicr;
					3'd2: r.op = opRldic;
					3'd3: r.op = opRldimi;
					default: r.op = opNone;
				endcase
				if (w[27:30] == 4'd8)
					r.op = opRldcl;
				else if (w[27:30] == 4'd9)
					r.op = opRldcr;
				r.reg3 = w[16:20];
				r.imm  = {18'd0, w[21:26]};
				r.bit1 = w[30];
				r.bit2 = w[31];
				r.unit = fxCode;
			end
			opcodeAddi, opcodeAddis, opcodeLwz, opcodeStw: begin
				r.op   = (w[0:5] == opcodeAddi) ? opAddi :
					(w[0:5] == opcodeAddis) ? opAddis :
					(w[0:5] == opcodeLwz) ? opLwz : opStw;
				r.imm  = {8'd0, w[16:31]};
				r.unit = (w[0] == 1'b1) ? ldStCode : fxCode; // 32 and 36 are memory ops
			end
			opcodeB: begin
				r.op   = opB;
				r.imm  = w[6:29];
				r.bit1 = w[30]; // AA
				r.bit2 = w[31]; // LK
				r.unit = branchCode;
			end
			default: r.op = opNone;
		endcase
		if (r.op != opNone && r.op != opB) begin
			r.reg1 = w[6:10];
			r.reg2 = w[11:15];
		end
		r.valid   = (r.op != opNone);
		r.illegal = (r.op == opNone);
		return r;
	endfunction

	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11
	endfunction

	task automatic drawBits(input int count, output logic [31:0] bits);
		bits = '0;
		for (int k = 0; k < count; k++) begin
			bits = {bits[30:0], lfsrState[15]};
			lfsrState = lfsrStep(lfsrState);
		end
	endtask

	// one word per cycle with its result checked two cycles later
	task automatic driveWord(input string testName, input logic en,
		input logic [0:instrWidth-1] w);
		@(posedge clock_i);
		#1;
		if (expQ.size() == 2)
			compareRecord(nameQ.pop_front(), expQ.pop_front());
		enable_i      = en;
		instruction_i = w;
		expQ.push_back(expectedRecord(en, w));
		nameQ.push_back(testName);
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////
	task automatic testReset();
		checkFlag("reset", "valid", 1'b0, valid_o);
		checkFlag("reset", "illegal", 1'b0, illegal_o);
		checkOp("reset", opNone, op_o);
		checkReg("reset", "reg1", '0, reg1_o);
		checkReg("reset", "reg2", '0, reg2_o);
		checkReg("reset", "reg3", '0, reg3_o);
		checkImm("reset", '0, imm_o);
		checkFlag("reset", "bit1", 1'b0, bit1_o);
		checkFlag("reset", "bit2", 1'b0, bit2_o);
		checkUnit("reset", '0, unitCode_o);
	endtask

	task automatic testMdRotates();
		logic [31:0] bits;
		logic [0:instrWidth-1] w;
		for (int i = 0; i < mdWords; i++) begin
			drawBits(32, bits);
			w = bits;
			w[0:5]   = opcodeMd;
			w[27:29] = {1'b0, i[1:0]}; // cycles 0 to 3
			driveWord("mdRotates", 1'b1, w);
		end
	endtask

	task automatic testMdsRotates();
		logic [31:0] bits;
		logic [0:instrWidth-1] w;
		for (int i = 0; i < mdsWords; i++) begin
			drawBits(32, bits);
			w = bits;
			w[0:5]   = opcodeMd;
			w[27:30] = i[0] ? 4'd9 : 4'd8;
			driveWord("mdsRotates", 1'b1, w);
		end
	endtask

	task automatic testDForm();
		logic [31:0] bits;
		logic [0:instrWidth-1] w;
		logic [0:5] ops [0:3];
		ops[0] = opcodeAddi;
		ops[1] = opcodeAddis;
		ops[2] = opcodeLwz;
		ops[3] = opcodeStw;
		for (int i = 0; i < dWords; i++) begin
			drawBits(32, bits);
			w = bits;
			w[0:5] = ops[i % 4];
			driveWord("dForm", 1'b1, w);
		end
	endtask

	task automatic testBranch();
		logic [31:0] bits;
		logic [0:instrWidth-1] w;
		for (int i = 0; i < branchWords; i++) begin
			drawBits(32, bits);
			w = bits;
			w[0:5]   = opcodeB;
			w[30:31] = i[1:0];  // every AA/LK pair
			driveWord("branch", 1'b1, w);
		end
	endtask

	task automatic testIllegal();
		logic [31:0] bits;
		logic [0:instrWidth-1] w;
		logic [0:5] unlisted [0:5];
		unlisted[0] = 6'd0;
		unlisted[1] = 6'd1;
		unlisted[2] = 6'd31;
		unlisted[3] = 6'd63;
		unlisted[4] = 6'd19;
		unlisted[5] = 6'd33;
		for (int i = 0; i < 6; i++) begin
			drawBits(32, bits);
			w = bits;
			w[0:5]   = opcodeMd;
			w[27:30] = 4'd10 + i[3:0]; // 10 to 15 are MD codes 5 to 7
			driveWord("illegalMd", 1'b1, w);
			w[0:5] = unlisted[i];
			driveWord("illegalOpcode", 1'b1, w);
			if (i % 2 == 0)
				driveWord("idle", 1'b0, w);
		end
		driveWord("idle", 1'b0, '0);
	endtask

	task automatic testStream();
		logic [31:0] bits;
		logic [31:0] sel;
		logic [0:instrWidth-1] w;
		for (int i = 0; i < streamWords; i++) begin
			drawBits(32, bits);
			drawBits(3, sel);
			w = bits;
			case (sel[2:0])
				3'd0: w[0:5] = opcodeMd;
				3'd1: w[0:5] = opcodeAddi;
				3'd2: w[0:5] = opcodeAddis;
				3'd3: w[0:5] = opcodeLwz;
				3'd4: w[0:5] = opcodeStw;
				3'd5: w[0:5] = opcodeB;
				default: w[0:5] = bits[31:26]; // fully random word
			endcase
			driveWord("backToBack", 1'b1, w);
		end
	endtask

	initial begin
		rstN_i        = 1'b0;
		enable_i      = 1'b0;
		instruction_i = '0;
		lfsrState     = 16'd73;
		repeat (resetCycles) @(posedge clock_i);
		#1;
		rstN_i = 1'b1;
		testReset();
		testMdRotates();
		testMdsRotates();
		testDForm();
		testBranch();
		testIllegal();
		testStream();
		repeat (flushSteps) driveWord("flush", 1'b0, '0);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== all.f ====
hdl/decodePkg.sv
hdl/mdFormatDecoder.sv
hdl/dFormatDecoder.sv
hdl/iFormatDecoder.sv
hdl/dispatchSelect.sv
hdl/decodeStage.sv
testbench/decodeStageTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary -f all.f --top-module decodeStageTb --Mdir "$buildDir" -o simv
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$buildDir/simv" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

if grep -q "SIMULATION FAILED" "$logFile"; then
	echo "simulation reported failure"
	exit 1
fi
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi

echo "simulation finished without failure"
exit 0
